/* design/rv_pipe_pkg.sv */
////////////////////
// Shared types of the rv_pipe front end
// Only the OP, OP-IMM and BRANCH major opcodes are decoded, everything else is illegal
// Struct layouts are packed, so field order is part of the bit layout
////////////////////
package rv_pipe_pkg;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPCODE_OPIMM  = 7'h13,
    OPCODE_OP     = 7'h33,
    OPCODE_BRANCH = 7'h63
  } opcode_e;

  // ALU operations, ADD doubles as the harmless default
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  ////////////////////
  // Pipeline payloads
  ////////////////////

  // Fetch to decode, the raw word and the address it was fetched from
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
  } if_id_pipe_t;

  // Decode to execute, operands are already resolved including forwarding
  typedef struct packed {
    alu_op_e     alu_op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [4:0]  rd;
    logic        rf_we;
    logic        is_branch;
    logic        branch_ne;
    logic [31:0] branch_target;
    logic        illegal;
    logic [31:0] pc;
  } id_ex_pipe_t;

  // Controller commands to the fetch and decode stages
  typedef struct packed {
    logic halt_id;
    logic kill_if;
    logic kill_id;
  } ctrl_fsm_t;

  // Retirement report, one per instruction leaving EX
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        rf_we;
    logic        illegal;
  } retire_t;

endpackage

/* design/pipe_reg.sv */
////////////////////
// One-entry valid/ready pipeline register
// A flush drops the entry and wins over a load in the same cycle
// Only the valid bit is reset, the payload is don't-care while empty
////////////////////
module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i,
  input  logic     flush_i
);

  logic     valid_q;
  payload_t data_q;

  // Space is available when empty or when the current entry leaves this cycle
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      // Either refill or drain, depending on what upstream offers
      valid_q <= in_valid_i;
    end
  end

  // Payload only moves on a real transfer
  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o && !flush_i) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

/* design/if_stage.sv */
////////////////////
// Fetch stage with program counter and fetch-to-decode register
// instr_i must be the word at fetch_pc_o whenever instr_valid_i is high
// A taken branch redirects the PC and discards whatever is accepted that cycle
////////////////////
module if_stage #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic [31:0]              instr_i,
  input  logic                     instr_valid_i,
  input  rv_pipe_pkg::ctrl_fsm_t   ctrl_i,
  input  logic                     branch_taken_i,
  input  logic [31:0]              branch_target_i,
  input  logic                     id_ready_i,
  output logic [31:0]              fetch_pc_o,
  output logic                     if_ready_o,
  output logic                     if_id_valid_o,
  output rv_pipe_pkg::if_id_pipe_t if_id_o
);
  import rv_pipe_pkg::*;

  logic [31:0] pc_q;
  logic        accept;
  if_id_pipe_t if_id_d;

  // Handshake with the external instruction source
  assign accept = instr_valid_i && if_ready_o;

  // Redirect has priority, an accepted word on the wrong path is flushed below
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else if (branch_taken_i) begin
      pc_q <= branch_target_i;
    end else if (accept) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign if_id_d    = '{instr: instr_i, pc: pc_q};
  assign fetch_pc_o = pc_q;

  // Fetch-to-decode register, if_ready_o falls once it is full and decode stalls
  pipe_reg #(
    .payload_t (if_id_pipe_t)
  ) u_if_id_reg (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (instr_valid_i),
    .in_data_i   (if_id_d),
    .in_ready_o  (if_ready_o),
    .out_valid_o (if_id_valid_o),
    .out_data_o  (if_id_o),
    .out_ready_i (id_ready_i),
    .flush_i     (ctrl_i.kill_if)
  );

endmodule

/* design/register_file.sv */
////////////////////
// 32 x 32-bit register file, two combinational reads and one write
// Register x0 is never written and always reads as zero
// A write is visible to reads only after the clock edge, no internal bypass
////////////////////
module register_file (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o
);

  logic [31:0] regs_q [32];

  // Whole array clears on reset
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 is forced to zero on the read side as well
  assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs_q[raddr_b_i];

endmodule

/* design/id_stage.sv */
////////////////////
// Decode stage for ADD/SUB/AND/OR/XOR, their immediate forms, BEQ and BNE
// Operands come from the register file with a bypass from the instruction in EX
// decode_valid is the stage's own valid, id_valid_o is the decode-to-execute register
// An illegal word still moves down the pipe, but without write or branch
////////////////////
module id_stage (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     if_id_valid_i,
  input  rv_pipe_pkg::if_id_pipe_t if_id_i,
  input  rv_pipe_pkg::ctrl_fsm_t   ctrl_i,
  input  logic                     ex_ready_i,
  input  logic [31:0]              rf_rdata_a_i,
  input  logic [31:0]              rf_rdata_b_i,
  input  logic                     fwd_valid_i,
  input  logic [4:0]               fwd_rd_i,
  input  logic [31:0]              fwd_data_i,
  output logic                     id_ready_o,
  output logic                     id_valid_o,
  output logic [4:0]               rf_raddr_a_o,
  output logic [4:0]               rf_raddr_b_o,
  output rv_pipe_pkg::id_ex_pipe_t id_ex_o
);
  import rv_pipe_pkg::*;

  logic [31:0] instr;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  alu_op_e     alu_op;
  logic        rf_we;
  logic        is_branch;
  logic        use_imm;
  logic        illegal;
  logic        decode_valid;
  logic        reg_ready;
  id_ex_pipe_t id_ex_d;

  ////////////////////
  // Field extraction
  ////////////////////

  assign instr  = if_id_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // I-type and B-type immediates, both sign-extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  ////////////////////
  // Decoder
  ////////////////////

  always_comb begin
    alu_op    = ALU_ADD;
    rf_we     = 1'b0;
    is_branch = 1'b0;
    use_imm   = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OPCODE_OPIMM: begin
        rf_we   = 1'b1;
        use_imm = 1'b1;
        case (funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      OPCODE_OP: begin
        rf_we = 1'b1;
        // SUB is the only legal encoding with a nonzero funct7
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = ALU_ADD;
          {7'h20, 3'b000}: alu_op = ALU_SUB;
          {7'h00, 3'b100}: alu_op = ALU_XOR;
          {7'h00, 3'b110}: alu_op = ALU_OR;
          {7'h00, 3'b111}: alu_op = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      OPCODE_BRANCH: begin
        // Only BEQ (000) and BNE (001)
        if (funct3[2:1] == 2'b00) begin
          is_branch = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
    // Strip every side effect from an illegal word
    if (illegal) begin
      rf_we     = 1'b0;
      is_branch = 1'b0;
      alu_op    = ALU_ADD;
    end
  end

  ////////////////////
  // Operands and forwarding
  ////////////////////

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  // The instruction in EX writes at the end of this cycle, so take its result directly
  assign rs1_val = (fwd_valid_i && (fwd_rd_i != 5'd0) && (fwd_rd_i == rs1)) ?
                   fwd_data_i : rf_rdata_a_i;
  assign rs2_val = (fwd_valid_i && (fwd_rd_i != 5'd0) && (fwd_rd_i == rs2)) ?
                   fwd_data_i : rf_rdata_b_i;

  assign id_ex_d = '{
    alu_op:        alu_op,
    operand_a:     rs1_val,
    operand_b:     use_imm ? imm_i : rs2_val,
    rd:            instr[11:7],
    rf_we:         rf_we,
    is_branch:     is_branch,
    branch_ne:     funct3[0],
    branch_target: if_id_i.pc + imm_b,
    illegal:       illegal,
    pc:            if_id_i.pc
  };

  ////////////////////
  // Halt and kill
  ////////////////////

  // Halt freezes the word in the fetch-to-decode register, kill drains it
  assign decode_valid = if_id_valid_i && !ctrl_i.halt_id && !ctrl_i.kill_id;
  assign id_ready_o   = ctrl_i.kill_id || (!ctrl_i.halt_id && reg_ready);

  // EX always drains this register, so no flush is needed here
  pipe_reg #(
    .payload_t (id_ex_pipe_t)
  ) u_id_ex_reg (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (decode_valid),
    .in_data_i   (id_ex_d),
    .in_ready_o  (reg_ready),
    .out_valid_o (id_valid_o),
    .out_data_o  (id_ex_o),
    .out_ready_i (ex_ready_i),
    .flush_i     (1'b0)
  );

endmodule

/* design/ex_stage.sv */
////////////////////
// Execute stage, the last stage of the pipe
// Works directly on the decode-to-execute register, results are combinational
// The register write lands on the edge that ends the EX cycle
////////////////////
module ex_stage (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     id_valid_i,
  input  rv_pipe_pkg::id_ex_pipe_t id_ex_i,
  output logic                     ex_ready_o,
  output logic                     branch_taken_o,
  output logic [31:0]              branch_target_o,
  output logic                     rf_we_o,
  output logic [4:0]               rf_waddr_o,
  output logic [31:0]              rf_wdata_o,
  output logic                     retire_valid_o,
  output rv_pipe_pkg::retire_t     retire_o
);
  import rv_pipe_pkg::*;

  logic        ready_q;
  logic        fire;
  logic        cond_met;
  logic [31:0] alu_result;

  // Ready comes up on the first edge after reset release and stays up
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  assign ex_ready_o = ready_q;
  assign fire       = id_valid_i && ready_q;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_SUB: alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_AND: alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      ALU_OR:  alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_XOR: alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      default: alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
    endcase
  end

  // BEQ compares equal, BNE inverts it
  assign cond_met        = (id_ex_i.operand_a == id_ex_i.operand_b) ^ id_ex_i.branch_ne;
  assign branch_taken_o  = fire && id_ex_i.is_branch && cond_met;
  assign branch_target_o = id_ex_i.branch_target;

  // Write-back port, also used as the forwarding source by decode
  assign rf_we_o    = fire && id_ex_i.rf_we;
  assign rf_waddr_o = id_ex_i.rd;
  assign rf_wdata_o = alu_result;

  assign retire_valid_o = fire;
  assign retire_o = '{
    pc:      id_ex_i.pc,
    rd:      id_ex_i.rd,
    data:    alu_result,
    rf_we:   id_ex_i.rf_we,
    illegal: id_ex_i.illegal
  };

endmodule

/* design/controller.sv */
////////////////////
// Pipeline controller for halt and kill
// halt_i is sampled once, so halt acts one cycle after it is raised
// A taken branch kills fetch and decode in the same cycle
////////////////////
module controller (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   halt_i,
  input  logic                   branch_taken_i,
  output rv_pipe_pkg::ctrl_fsm_t ctrl_o
);

  logic halt_q;

  // Bring the external halt level into the pipeline clock domain
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      halt_q <= 1'b0;
    end else begin
      halt_q <= halt_i;
    end
  end

  // Both younger instructions are on the wrong path after a taken branch
  assign ctrl_o.kill_if = branch_taken_i;
  assign ctrl_o.kill_id = branch_taken_i;

  // Kill always wins over halt, otherwise the wrong path would be held
  assign ctrl_o.halt_id = halt_q && !branch_taken_i;

endmodule

/* design/rv_pipe_top.sv */
////////////////////
// Three-stage RV32I subset pipeline, fetch, decode and execute
// The instruction source must answer for fetch_pc_o, and a new PC follows each acceptance
// Up to three instructions are in flight, halt_i only stalls decode
////////////////////
module rv_pipe_top #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [31:0]          instr_i,
  input  logic                 instr_valid_i,
  input  logic                 halt_i,
  output logic [31:0]          fetch_pc_o,
  output logic                 if_ready_o,
  output logic                 branch_taken_o,
  output logic                 retire_valid_o,
  output rv_pipe_pkg::retire_t retire_o
);
  import rv_pipe_pkg::*;

  ctrl_fsm_t   ctrl;
  logic [31:0] branch_target;
  logic        if_id_valid;
  if_id_pipe_t if_id;
  logic        id_ready;
  logic        id_valid;
  id_ex_pipe_t id_ex;
  logic        ex_ready;
  logic [4:0]  rf_raddr_a;
  logic [4:0]  rf_raddr_b;
  logic [31:0] rf_rdata_a;
  logic [31:0] rf_rdata_b;
  logic        rf_we;
  logic [4:0]  rf_waddr;
  logic [31:0] rf_wdata;

  if_stage #(
    .BOOT_ADDR (BOOT_ADDR)
  ) u_if_stage (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .instr_i         (instr_i),
    .instr_valid_i   (instr_valid_i),
    .ctrl_i          (ctrl),
    .branch_taken_i  (branch_taken_o),
    .branch_target_i (branch_target),
    .id_ready_i      (id_ready),
    .fetch_pc_o      (fetch_pc_o),
    .if_ready_o      (if_ready_o),
    .if_id_valid_o   (if_id_valid),
    .if_id_o         (if_id)
  );

  // The write-back port of EX doubles as the forwarding path
  id_stage u_id_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .if_id_valid_i (if_id_valid),
    .if_id_i       (if_id),
    .ctrl_i        (ctrl),
    .ex_ready_i    (ex_ready),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .fwd_valid_i   (rf_we),
    .fwd_rd_i      (rf_waddr),
    .fwd_data_i    (rf_wdata),
    .id_ready_o    (id_ready),
    .id_valid_o    (id_valid),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .id_ex_o       (id_ex)
  );

  ex_stage u_ex_stage (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .id_valid_i      (id_valid),
    .id_ex_i         (id_ex),
    .ex_ready_o      (ex_ready),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata),
    .retire_valid_o  (retire_valid_o),
    .retire_o        (retire_o)
  );

  register_file u_register_file (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

  controller u_controller (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .halt_i         (halt_i),
    .branch_taken_i (branch_taken_o),
    .ctrl_o         (ctrl)
  );

endmodule

/* dv/id_stage_checker.sv */
////////////////////
// Property checker for the decode stage and the controller commands
// Hooked to internal nets of the DUT by hierarchical connection
// Every property is disabled while reset is asserted
////////////////////
module id_stage_checker (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  rv_pipe_pkg::ctrl_fsm_t   ctrl_i,
  input  logic                     if_id_valid_i,
  input  rv_pipe_pkg::if_id_pipe_t if_id_i,
  input  logic                     id_ready_i,
  input  logic                     decode_valid_i,
  input  logic                     id_valid_i,
  input  rv_pipe_pkg::id_ex_pipe_t id_ex_i,
  output int                       error_count_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    error_count_o = 0;
  end

  ////////////////////
  // Decode output
  ////////////////////

  // An illegal word travels on but must never write or branch
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (id_valid_i && id_ex_i.illegal) |-> (!id_ex_i.rf_we && !id_ex_i.is_branch))
  else begin
    error_count_o++;
    $display("FAILED id_ex_o.rf_we/is_branch for illegal word at pc %h: %h/%h, expected 0/0",
             $sampled(id_ex_i.pc), $sampled(id_ex_i.rf_we), $sampled(id_ex_i.is_branch));
  end

  // Only words accepted from the source can sit in the fetch-to-decode register
  assert property (@(posedge clk) disable iff (!rst_n_i)
    if_id_valid_i |-> !$isunknown(if_id_i.instr))
  else begin
    error_count_o++;
    $display("Fetch-to-decode entry at pc %h holds an unknown instruction",
             $sampled(if_id_i.pc));
  end

  ////////////////////
  // Halt and kill
  ////////////////////

  // Halt freezes decode, it neither accepts nor passes on an instruction
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (ctrl_i.halt_id && !ctrl_i.kill_id) |-> (!id_ready_i && !decode_valid_i))
  else begin
    error_count_o++;
    $display("FAILED id_ready_o/decode_valid under halt: %h/%h, expected 0/0",
             $sampled(id_ready_i), $sampled(decode_valid_i));
  end

  // Nothing new reaches execute on the edge after a halted cycle
  assert property (@(posedge clk) disable iff (!rst_n_i)
    ctrl_i.halt_id |=> !id_valid_i)
  else begin
    error_count_o++;
    $display("Decode stage handed an instruction to execute while halted");
  end

  // Kill drains decode, the held word is dropped and the stage stays open
  assert property (@(posedge clk) disable iff (!rst_n_i)
    ctrl_i.kill_id |-> (id_ready_i && !decode_valid_i))
  else begin
    error_count_o++;
    $display("FAILED id_ready_o/decode_valid under kill: %h/%h, expected 1/0",
             $sampled(id_ready_i), $sampled(decode_valid_i));
  end

endmodule

/* dv/rv_pipe_tb.sv */
////////////////////
// Testbench for rv_pipe_top with a random program and an instruction-set model
// Branches only jump forward, so every run ends at the last program word
// instr_valid_i and halt_i are random, a watchdog bounds the run length
////////////////////
module rv_pipe_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pipe_pkg::*;

  localparam logic [31:0] BOOT_ADDR  = 32'h0000_1000;
  localparam int          PROG_LEN   = 64;
  localparam logic [31:0] END_ADDR   = BOOT_ADDR + 4 * PROG_LEN;
  localparam int          CLK_PERIOD = 8;
  localparam logic [31:0] SEED       = 32'd56138;

  // One expected retirement, target is the next pc in program order
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        rf_we;
    logic        illegal;
    logic        taken;
    logic [31:0] target;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr;
  logic        instr_valid;
  logic        halt;
  logic [31:0] fetch_pc;
  logic        if_ready;
  logic        branch_taken;
  logic        retire_valid;
  retire_t     retire;

  logic [31:0] prog [PROG_LEN];
  expect_t     exp_q [$];
  logic [31:0] rng;
  int          retired = 0;
  int          expected_total = 0;
  int          tb_errors = 0;
  int          checker_errors;
  logic        redirect_pending = 1'b0;
  logic [31:0] redirect_pc;

  rv_pipe_top #(
    .BOOT_ADDR (BOOT_ADDR)
  ) uut (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .instr_i        (instr),
    .instr_valid_i  (instr_valid),
    .halt_i         (halt),
    .fetch_pc_o     (fetch_pc),
    .if_ready_o     (if_ready),
    .branch_taken_o (branch_taken),
    .retire_valid_o (retire_valid),
    .retire_o       (retire)
  );

  id_stage_checker u_checker (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .ctrl_i         (uut.u_controller.ctrl_o),
    .if_id_valid_i  (uut.u_id_stage.if_id_valid_i),
    .if_id_i        (uut.u_id_stage.if_id_i),
    .id_ready_i     (uut.u_id_stage.id_ready_o),
    .decode_valid_i (uut.u_id_stage.decode_valid),
    .id_valid_i     (uut.u_id_stage.id_valid_o),
    .id_ex_i        (uut.u_id_stage.id_ex_o),
    .error_count_o  (checker_errors)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  ////////////////////
  // Encoding helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPCODE_OPIMM};
  endfunction

  // B-type scatters the offset, bit 0 is implied zero
  function automatic logic [31:0] b_type_word(input logic [12:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
  endfunction

  // funct3 codes shared by ADD, XOR, OR and AND in both formats
  function automatic logic basic_funct3(input logic [2:0] f3);
    return (f3 == 3'b000) || (f3 == 3'b100) || (f3 == 3'b110) || (f3 == 3'b111);
  endfunction

  function automatic logic [31:0] reference_alu(input logic [2:0] f3, input logic sub,
                                                input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b100:  return x ^ y;
      3'b110:  return x | y;
      3'b111:  return x & y;
      default: return sub ? x - y : x + y;
    endcase
  endfunction

  ////////////////////
  // Program and model
  ////////////////////

  // Only x0..x7 are used so that dependent neighbours are frequent
  task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3_pick [4];
    int          kind;
    int          hop;
    f3_pick = '{3'b000, 3'b100, 3'b110, 3'b111};
    for (int i = 0; i < PROG_LEN; i++) begin
      rng  = xorshift32(rng);
      r    = rng;
      rd   = {2'b00, r[10:8]};
      rs1  = {2'b00, r[13:11]};
      rs2  = {2'b00, r[16:14]};
      kind = int'(r[3:0]);
      if (kind < 6) begin
        prog[i] = i_type_word(r[31:20], rs1, f3_pick[r[5:4]], rd);
      end else if (kind < 11) begin
        // SUB once in a while, otherwise one of the funct7 zero forms
        if (r[6]) begin
          prog[i] = r_type_word(7'h20, rs2, rs1, 3'b000, rd);
        end else begin
          prog[i] = r_type_word(7'h00, rs2, rs1, f3_pick[r[5:4]], rd);
        end
      end else if (kind < 14) begin
        // Forward hop of 1..4 words, never past the end of the program
        hop = 1 + int'(r[18:17]);
        if (hop > PROG_LEN - i) begin
          hop = PROG_LEN - i;
        end
        prog[i] = b_type_word(13'(hop * 4), rs2, rs1, {2'b00, r[19]});
      end else begin
        case (r[5:4])
          2'd0:    prog[i] = {r[31:7], 7'h03};
          2'd1:    prog[i] = r_type_word(7'h20, rs2, rs1, 3'b111, rd);
          2'd2:    prog[i] = {r[31:15], 3'b100, r[11:7], OPCODE_BRANCH};
          default: prog[i] = i_type_word(r[31:20], rs1, 3'b001, rd);
        endcase
      end
    end
  endtask

  // Runs the program in order and queues one record per retiring instruction
  task automatic build_expected();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_b;
    logic [2:0]  f3;
    logic        legal;
    expect_t     e;
    for (int k = 0; k < 32; k++) begin
      regs[k] = '0;
    end
    pc = BOOT_ADDR;
    while (pc < END_ADDR) begin
      w      = prog[(pc - BOOT_ADDR) >> 2];
      f3     = w[14:12];
      a      = regs[w[19:15]];
      b      = regs[w[24:20]];
      imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      legal  = 1'b0;
      e      = '0;
      e.pc   = pc;
      e.rd   = w[11:7];
      case (w[6:0])
        OPCODE_OPIMM: begin
          legal   = basic_funct3(f3);
          e.rf_we = legal;
          e.data  = reference_alu(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
        end
        OPCODE_OP: begin
          legal   = ((w[31:25] == 7'h00) && basic_funct3(f3)) ||
                    ((w[31:25] == 7'h20) && (f3 == 3'b000));
          e.rf_we = legal;
          e.data  = reference_alu(f3, w[30], a, b);
        end
        OPCODE_BRANCH: begin
          legal   = (f3 == 3'b000) || (f3 == 3'b001);
          e.taken = legal && ((a == b) != f3[0]);
        end
        default: legal = 1'b0;
      endcase
      e.illegal = !legal;
      e.target  = e.taken ? pc + imm_b : pc + 32'd4;
      if (e.rf_we && (e.rd != 5'd0)) begin
        regs[e.rd] = e.data;
      end
      exp_q.push_back(e);
      pc = e.target;
    end
  endtask

  ////////////////////
  // Checks and stimulus
  ////////////////////

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      tb_errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_retire();
    expect_t e;
    if (exp_q.size() == 0) begin
      tb_errors++;
      $display("Instruction at pc %h retired after the program had completed", retire.pc);
    end else begin
      e = exp_q.pop_front();
      retired++;
      compare_word("retire_o.pc", retire.pc, e.pc);
      compare_word("retire_o.rd", retire.rd, e.rd);
      compare_word("retire_o.rf_we", retire.rf_we, e.rf_we);
      compare_word("retire_o.illegal", retire.illegal, e.illegal);
      compare_word("branch_taken_o", branch_taken, e.taken);
      // Data only matters for a write, branches and illegal words leave it open
      if (e.rf_we) begin
        compare_word("retire_o.data", retire.data, e.data);
      end
      if (e.taken) begin
        redirect_pending = 1'b1;
        redirect_pc      = e.target;
      end
    end
  endtask

  // Outputs settle well before the falling edge, so sample there
  always @(negedge clk) begin
    if (rst_n) begin
      if (redirect_pending) begin
        compare_word("fetch_pc_o after taken branch", fetch_pc, redirect_pc);
        redirect_pending = 1'b0;
      end
      if (retire_valid) begin
        check_retire();
      end
    end
  end

  // Source answers for the current fetch_pc_o, and goes quiet past the program end
  task automatic drive_inputs();
    logic in_range;
    rng         = xorshift32(rng);
    in_range    = (fetch_pc >= BOOT_ADDR) && (fetch_pc < END_ADDR);
    instr_valid = in_range && (rng[1:0] != 2'b00);
    instr       = instr_valid ? prog[(fetch_pc - BOOT_ADDR) >> 2] : 'x;
    // Halt comes in short bursts
    if (halt) begin
      halt = (rng[5:4] != 2'b00);
    end else begin
      halt = (rng[11:8] == 4'h0);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    halt        = 1'b0;
    rng         = SEED;
    build_program();
    build_expected();
    expected_total = exp_q.size();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    #1;
    // State straight out of reset, before the first active edge
    compare_word("fetch_pc_o", fetch_pc, BOOT_ADDR);
    compare_word("if_ready_o", if_ready, 1'b1);
    compare_word("retire_valid_o", retire_valid, 1'b0);
    compare_word("branch_taken_o", branch_taken, 1'b0);
    while (retired < expected_total) begin
      @(posedge clk);
      #1;
      drive_inputs();
    end
    instr_valid = 1'b0;
    halt        = 1'b0;
    // A few idle cycles so that a stray late retirement is still caught
    repeat (5) @(posedge clk);
    $display("Retired %0d of %0d, %0d testbench errors, %0d checker errors",
             retired, expected_total, tb_errors, checker_errors);
    if ((tb_errors == 0) && (checker_errors == 0) && (retired == expected_total)) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Generous bound, a busy run needs only a few cycles per instruction
  initial begin
    repeat (PROG_LEN * 20) @(posedge clk);
    $display("Watchdog expired, retired %0d of %0d, %0d testbench errors, %0d checker errors",
             retired, expected_total, tb_errors, checker_errors);
    $display("Something failed");
    $finish;
  end

endmodule

/* rv_pipe.f */
design/rv_pipe_pkg.sv
design/pipe_reg.sv
design/if_stage.sv
design/register_file.sv
design/id_stage.sv
design/ex_stage.sv
design/controller.sv
design/rv_pipe_top.sv
dv/id_stage_checker.sv
dv/rv_pipe_tb.sv
